/* hdl/fecha_pkg.sv */
package fecha_pkg;

   ////////////////////////////////////////
   // Field data
   ////////////////////////////////////////

   // Two BCD digits, tens in the upper nibble
   typedef logic [7:0] bcd_t;

   localparam int NUM_FIELDS = 3;

   // Cursor position, value doubles as field index
   typedef enum logic [1:0]
   {
      POS_DIA = 2'd0,
      POS_MES = 2'd1,
      POS_ANO = 2'd2
   } pos_t;

   // Edit opcode from the up/down buttons
   typedef enum logic [1:0]
   {
      ADJ_NONE = 2'd0,
      ADJ_UP   = 2'd1,
      ADJ_DOWN = 2'd2
   } adjust_t;

   ////////////////////////////////////////
   // Limits and bus addresses
   ////////////////////////////////////////

   // Index 0 day, 1 month, 2 year
   localparam bcd_t FIELD_MIN [NUM_FIELDS] = '{8'h01, 8'h01, 8'h01};
   localparam bcd_t FIELD_MAX [NUM_FIELDS] = '{8'h31, 8'h12, 8'h99};

   // Address bytes sent ahead of each data byte
   localparam logic [7:0] ADDR_DIA = 8'd36;
   localparam logic [7:0] ADDR_MES = 8'd37;
   localparam logic [7:0] ADDR_ANO = 8'd38;

   // Edit tick period in clocks
   localparam int TICK_DIV_DEFAULT = 4;

endpackage

/* hdl/fecha_control.sv */
module fecha_control
   import fecha_pkg::*;
#(
   parameter int TICK_DIV = TICK_DIV_DEFAULT
)
(
   input  logic                  reloj,
   input  logic                  resetM,
   input  logic                  read,
   input  logic [3:0]            load_sel,
   input  bcd_t                  dia_in,
   input  bcd_t                  mes_in,
   input  bcd_t                  ano_in,
   input  logic [3:0]            buttons,
   output pos_t                  pos_f,
   output logic [NUM_FIELDS-1:0] edit_en,
   output adjust_t               adjust,
   output logic [NUM_FIELDS-1:0] load_en,
   output bcd_t [NUM_FIELDS-1:0] load_data
);

   localparam int CNT_W = $clog2(TICK_DIV);

   logic [CNT_W-1:0]      tick_cnt;
   logic                  tick;
   pos_t                  pos_next;
   bcd_t [NUM_FIELDS-1:0] load_in;

   ////////////////////////////////////////
   // Edit prescaler
   ////////////////////////////////////////

   assign tick = (tick_cnt == CNT_W'(TICK_DIV - 1));

   always_ff @(posedge reloj)
   begin
      if (resetM)
         tick_cnt <= '0;
      else if (tick)
         tick_cnt <= '0;
      else
         tick_cnt <= tick_cnt + 1'b1;
   end

   ////////////////////////////////////////
   // Cursor FSM
   ////////////////////////////////////////

   always_comb
   begin
      pos_next = pos_f;
      case (buttons[1:0])
         // Next field
         2'b01:
         begin
            case (pos_f)
               POS_DIA: pos_next = POS_MES;
               POS_MES: pos_next = POS_ANO;
               default: pos_next = POS_DIA;
            endcase
         end
         // Previous field
         2'b10:
         begin
            case (pos_f)
               POS_DIA: pos_next = POS_ANO;
               POS_ANO: pos_next = POS_MES;
               default: pos_next = POS_DIA;
            endcase
         end
         // Home
         2'b11:   pos_next = POS_DIA;
         default: pos_next = pos_f;
      endcase
   end

   always_ff @(posedge reloj)
   begin
      if (resetM)
         pos_f <= POS_DIA;
      else if (tick)
         pos_f <= pos_next;
   end

   // Old cursor value selects the field, so edit and move on one tick edit the old field
   always_comb
   begin
      for (int i = 0; i < NUM_FIELDS; i++)
         edit_en[i] = tick && (int'(pos_f) == i);
   end

   always_comb
   begin
      case (buttons[3:2])
         2'b10:   adjust = ADJ_UP;
         2'b01:   adjust = ADJ_DOWN;
         default: adjust = ADJ_NONE;
      endcase
   end

   ////////////////////////////////////////
   // Direct load capture
   ////////////////////////////////////////

   assign load_in = {ano_in, mes_in, dia_in};

   always_ff @(posedge reloj)
   begin
      if (resetM)
         load_en <= '0;
      else
         for (int i = 0; i < NUM_FIELDS; i++)
            load_en[i] <= read && (load_sel == 4'(i));
   end

   // Byte held until the next load of the same field
   always_ff @(posedge reloj)
   begin
      for (int i = 0; i < NUM_FIELDS; i++)
         if (read && (load_sel == 4'(i)))
            load_data[i] <= load_in[i];
   end

endmodule

/* hdl/fecha_field_editor.sv */
module fecha_field_editor
   import fecha_pkg::*;
#(
   parameter bcd_t MIN_BCD = 8'h01,
   parameter bcd_t MAX_BCD = 8'h99
)
(
   input  logic    reloj,
   input  logic    resetM,
   input  logic    edit_en,
   input  adjust_t adjust,
   input  logic    load_en,
   input  bcd_t    load_data,
   output bcd_t    field_value
);

   bcd_t step_value;

   ////////////////////////////////////////
   // BCD stepping
   ////////////////////////////////////////

   // Units carry into tens, top wraps to the minimum
   function automatic bcd_t bcd_inc(input bcd_t value);
      bcd_t result;
      if (value >= MAX_BCD)
         result = MIN_BCD;
      else if (value[3:0] >= 4'h9)
      begin
         result[7:4] = value[7:4] + 4'h1;
         result[3:0] = 4'h0;
      end
      else
      begin
         result[7:4] = value[7:4];
         result[3:0] = value[3:0] + 4'h1;
      end
      return result;
   endfunction

   // Units borrow from tens, bottom wraps to the maximum
   function automatic bcd_t bcd_dec(input bcd_t value);
      bcd_t result;
      if (value <= MIN_BCD)
         result = MAX_BCD;
      else if (value[3:0] == 4'h0)
      begin
         result[7:4] = value[7:4] - 4'h1;
         result[3:0] = 4'h9;
      end
      else
      begin
         result[7:4] = value[7:4];
         result[3:0] = value[3:0] - 4'h1;
      end
      return result;
   endfunction

   always_comb
   begin
      case (adjust)
         ADJ_UP:   step_value = bcd_inc(field_value);
         ADJ_DOWN: step_value = bcd_dec(field_value);
         default:  step_value = field_value;
      endcase
   end

   ////////////////////////////////////////
   // Field register
   ////////////////////////////////////////

   // Load wins over an edit on the same edge
   always_ff @(posedge reloj)
   begin
      if (resetM)
         field_value <= MIN_BCD;
      else if (load_en)
         field_value <= load_data;
      else if (edit_en)
         field_value <= step_value;
   end

endmodule

/* hdl/fecha_bus_sequencer.sv */
module fecha_bus_sequencer
   import fecha_pkg::*;
(
   input  logic                  reloj,
   input  logic                  resetM,
   input  logic                  enable_cont_16,
   input  logic                  enable_cont_fecha,
   input  bcd_t [NUM_FIELDS-1:0] field_value,
   output bcd_t                  dia_out,
   output bcd_t                  mes_out,
   output bcd_t                  ano_out
);

   // Address then data for each field
   typedef enum logic [2:0]
   {
      PH_DIA_ADDR = 3'd0,
      PH_DIA_DATA = 3'd1,
      PH_MES_ADDR = 3'd2,
      PH_MES_DATA = 3'd3,
      PH_ANO_ADDR = 3'd4,
      PH_ANO_DATA = 3'd5
   } phase_t;

   phase_t phase;
   phase_t phase_next;
   logic   step;

   assign step = enable_cont_16 && enable_cont_fecha;

   always_comb
   begin
      case (phase)
         PH_DIA_ADDR: phase_next = PH_DIA_DATA;
         PH_DIA_DATA: phase_next = PH_MES_ADDR;
         PH_MES_ADDR: phase_next = PH_MES_DATA;
         PH_MES_DATA: phase_next = PH_ANO_ADDR;
         PH_ANO_ADDR: phase_next = PH_ANO_DATA;
         default:     phase_next = PH_DIA_ADDR;
      endcase
   end

   always_ff @(posedge reloj)
   begin
      if (resetM)
         phase <= PH_DIA_ADDR;
      else if (step)
         phase <= phase_next;
   end

   ////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////

   // Written every clock from the current phase, other buses hold
   always_ff @(posedge reloj)
   begin
      if (resetM)
      begin
         dia_out <= '0;
         mes_out <= '0;
         ano_out <= '0;
      end
      else
      begin
         case (phase)
            PH_DIA_ADDR: dia_out <= ADDR_DIA;
            PH_DIA_DATA: dia_out <= field_value[POS_DIA];
            PH_MES_ADDR: mes_out <= ADDR_MES;
            PH_MES_DATA: mes_out <= field_value[POS_MES];
            PH_ANO_ADDR: ano_out <= ADDR_ANO;
            PH_ANO_DATA: ano_out <= field_value[POS_ANO];
            default:     dia_out <= dia_out;
         endcase
      end
   end

endmodule

/* hdl/bloque_fecha.sv */
module bloque_fecha
   import fecha_pkg::*;
#(
   parameter int TICK_DIV = TICK_DIV_DEFAULT
)
(
   input  logic       reloj,
   input  logic       resetM,
   input  logic       read,
   input  logic [3:0] load_sel,
   input  bcd_t       dia_in,
   input  bcd_t       mes_in,
   input  bcd_t       ano_in,
   input  logic [3:0] buttons,
   input  logic       enable_cont_16,
   input  logic       enable_cont_fecha,
   output bcd_t       dia_out,
   output bcd_t       mes_out,
   output bcd_t       ano_out,
   output pos_t       pos_f
);

   logic [NUM_FIELDS-1:0] edit_en;
   adjust_t               adjust;
   logic [NUM_FIELDS-1:0] load_en;
   bcd_t [NUM_FIELDS-1:0] load_data;
   bcd_t [NUM_FIELDS-1:0] field_value;

   ////////////////////////////////////////
   // Buttons, cursor and load capture
   ////////////////////////////////////////

   fecha_control #(
      .TICK_DIV (TICK_DIV)
   ) u_control (
      .reloj     (reloj),
      .resetM    (resetM),
      .read      (read),
      .load_sel  (load_sel),
      .dia_in    (dia_in),
      .mes_in    (mes_in),
      .ano_in    (ano_in),
      .buttons   (buttons),
      .pos_f     (pos_f),
      .edit_en   (edit_en),
      .adjust    (adjust),
      .load_en   (load_en),
      .load_data (load_data)
   );

   ////////////////////////////////////////
   // One editor per field
   ////////////////////////////////////////

   for (genvar i = 0; i < NUM_FIELDS; i++)
   begin : g_field
      fecha_field_editor #(
         .MIN_BCD (FIELD_MIN[i]),
         .MAX_BCD (FIELD_MAX[i])
      ) u_editor (
         .reloj       (reloj),
         .resetM      (resetM),
         .edit_en     (edit_en[i]),
         .adjust      (adjust),
         .load_en     (load_en[i]),
         .load_data   (load_data[i]),
         .field_value (field_value[i])
      );
   end

   // Address/data bytes out
   fecha_bus_sequencer u_sequencer (
      .reloj             (reloj),
      .resetM            (resetM),
      .enable_cont_16    (enable_cont_16),
      .enable_cont_fecha (enable_cont_fecha),
      .field_value       (field_value),
      .dia_out           (dia_out),
      .mes_out           (mes_out),
      .ano_out           (ano_out)
   );

endmodule

/* verif/tb_fecha_model.svh */
`ifndef TB_FECHA_MODEL_SVH
`define TB_FECHA_MODEL_SVH

////////////////////////////////////////
// Random bits
////////////////////////////////////////

logic [15:0] lfsr_state;

// Taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
   logic feedback;
   feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
   return {state[14:0], feedback};
endfunction

function automatic int random_bits(input int count);
   int result;
   result = 0;
   for (int k = 0; k < count; k++)
   begin
      result = (result << 1) | int'(lfsr_state[15]);
      lfsr_state = lfsr_next(lfsr_state);
   end
   return result;
endfunction

////////////////////////////////////////
// Reference rules
////////////////////////////////////////

function automatic int bcd_to_int(input bcd_t value);
   return value[7:4] * 10 + value[3:0];
endfunction

function automatic bcd_t int_to_bcd(input int value);
   bcd_t result;
   result[7:4] = 4'(value / 10);
   result[3:0] = 4'(value % 10);
   return result;
endfunction

// Up is 10, down is 01, wrap inside lo..hi
function automatic bcd_t bcd_step(input bcd_t value, input logic [1:0] code,
                                  input bcd_t lo, input bcd_t hi);
   int v;
   v = bcd_to_int(value);
   if (code == 2'b10)
      v = (v == bcd_to_int(hi)) ? bcd_to_int(lo) : v + 1;
   else if (code == 2'b01)
      v = (v == bcd_to_int(lo)) ? bcd_to_int(hi) : v - 1;
   return int_to_bcd(v);
endfunction

function automatic logic [1:0] cursor_next(input logic [1:0] pos, input logic [1:0] code);
   logic [1:0] result;
   case (code)
      2'b01:   result = (pos == 2'd2) ? 2'd0 : pos + 2'd1;
      2'b10:   result = (pos == 2'd0) ? 2'd2 : pos - 2'd1;
      2'b11:   result = 2'd0;
      default: result = pos;
   endcase
   return result;
endfunction

task automatic check_value(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
   if (actual !== expected)
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
endtask

`endif

/* verif/tb_bloque_fecha.sv */
module tb_bloque_fecha
   import fecha_pkg::*;
();

   localparam int TICK_DIV = TICK_DIV_DEFAULT;
   localparam bcd_t FIELD_ADDR [NUM_FIELDS] = '{ADDR_DIA, ADDR_MES, ADDR_ANO};

   logic       reloj;
   logic       resetM;
   logic       read;
   logic [3:0] load_sel;
   bcd_t       dia_in;
   bcd_t       mes_in;
   bcd_t       ano_in;
   logic [3:0] buttons;
   logic       enable_cont_16;
   logic       enable_cont_fecha;
   bcd_t       dia_out;
   bcd_t       mes_out;
   bcd_t       ano_out;
   pos_t       pos_f;
   string      test_name;

   // Model state as the DUT holds it after each rising edge
   logic                  model_valid;
   int                    m_cnt;
   int                    m_phase;
   logic [1:0]            m_pos;
   bcd_t                  m_field [NUM_FIELDS];
   bcd_t                  m_out [NUM_FIELDS];
   logic [NUM_FIELDS-1:0] m_load_pend;
   bcd_t                  m_load_val [NUM_FIELDS];

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at first error");
   endtask

   `include "tb_fecha_model.svh"

   bloque_fecha #(
      .TICK_DIV (TICK_DIV)
   ) uut (
      .reloj (reloj), .resetM (resetM), .read (read), .load_sel (load_sel),
      .dia_in (dia_in), .mes_in (mes_in), .ano_in (ano_in), .buttons (buttons),
      .enable_cont_16 (enable_cont_16), .enable_cont_fecha (enable_cont_fecha),
      .dia_out (dia_out), .mes_out (mes_out), .ano_out (ano_out), .pos_f (pos_f)
   );

   initial
   begin
      reloj = 1'b0;
      forever #10 reloj = ~reloj;
   end

   ////////////////////////////////////////
   // Reference model and compare
   ////////////////////////////////////////

   always @(posedge reloj)
   begin : model_update
      logic tick;
      bcd_t in_byte [NUM_FIELDS];
      int   f;
      if (model_valid)
      begin
         check_value({test_name, " pos_f"}, 8'(m_pos), 8'(pos_f));
         check_value({test_name, " dia_out"}, m_out[0], dia_out);
         check_value({test_name, " mes_out"}, m_out[1], mes_out);
         check_value({test_name, " ano_out"}, m_out[2], ano_out);
      end
      if (resetM)
      begin
         m_cnt = 0;
         m_phase = 0;
         m_pos = 2'd0;
         m_load_pend = '0;
         for (int i = 0; i < NUM_FIELDS; i++)
         begin
            m_field[i] = FIELD_MIN[i];
            m_out[i] = 8'h00;
         end
         model_valid = 1'b1;
      end
      else
      begin
         tick = (m_cnt == TICK_DIV - 1);
         in_byte = '{dia_in, mes_in, ano_in};
         // Bus byte from the phase and fields held before the edge
         f = m_phase / 2;
         m_out[f] = (m_phase % 2 == 0) ? FIELD_ADDR[f] : m_field[f];
         if (enable_cont_16 && enable_cont_fecha)
            m_phase = (m_phase == 5) ? 0 : m_phase + 1;
         for (int i = 0; i < NUM_FIELDS; i++)
         begin
            if (m_load_pend[i])
               m_field[i] = m_load_val[i];
            else if (tick && m_pos == i)
               m_field[i] = bcd_step(m_field[i], buttons[3:2], FIELD_MIN[i], FIELD_MAX[i]);
            m_load_pend[i] = read && (load_sel == i);
            if (m_load_pend[i])
               m_load_val[i] = in_byte[i];
         end
         if (tick)
            m_pos = cursor_next(m_pos, buttons[1:0]);
         m_cnt = tick ? 0 : m_cnt + 1;
      end
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   // Whole ticks, so each hold sees exactly that many tick edges
   task automatic hold_buttons(input logic [3:0] code, input int ticks);
      buttons = code;
      repeat (ticks * TICK_DIV) @(negedge reloj);
      buttons = 4'b0000;
   endtask

   task automatic run_to_phase(input int target, input int limit);
      int waited;
      waited = 0;
      enable_cont_16 = 1'b1;
      enable_cont_fecha = 1'b1;
      while (m_phase != target)
      begin
         @(negedge reloj);
         waited++;
         if (waited > limit)
            abort_run($sformatf("Sequencer never reached phase %0d", target));
      end
      enable_cont_16 = 1'b0;
      enable_cont_fecha = 1'b0;
   endtask

   task automatic sweep_sequencer();
      run_to_phase(5, 12);
      run_to_phase(0, 12);
   endtask

   task automatic wait_for_count(input int target, input int limit);
      int waited;
      waited = 0;
      while (m_cnt != target)
      begin
         @(negedge reloj);
         waited++;
         if (waited > limit)
            abort_run("Edit prescaler never reached the expected count");
      end
   endtask

   task automatic set_random_inputs();
      int lo [NUM_FIELDS];
      bcd_t value [NUM_FIELDS];
      for (int i = 0; i < NUM_FIELDS; i++)
      begin
         lo[i] = bcd_to_int(FIELD_MIN[i]);
         value[i] = int_to_bcd(lo[i] + random_bits(8) % (bcd_to_int(FIELD_MAX[i]) - lo[i] + 1));
      end
      dia_in = value[0];
      mes_in = value[1];
      ano_in = value[2];
   endtask

   initial
   begin
      lfsr_state = 16'd28483;
      model_valid = 1'b0;
      test_name = "reset";
      resetM = 1'b1;
      read = 1'b0;
      load_sel = 4'd0;
      dia_in = 8'h00;
      mes_in = 8'h00;
      ano_in = 8'h00;
      buttons = 4'b0000;
      enable_cont_16 = 1'b0;
      enable_cont_fecha = 1'b0;
      repeat (3) @(posedge reloj);
      @(negedge reloj);
      resetM = 1'b0;
      check_value("reset dia_out", 8'h00, dia_out);
      check_value("reset mes_out", 8'h00, mes_out);
      check_value("reset ano_out", 8'h00, ano_out);
      check_value("reset pos_f", 8'h00, 8'(pos_f));
      sweep_sequencer();

      test_name = "cursor";
      for (int n = 0; n < 24; n++)
         hold_buttons(4'(random_bits(2)), 1);

      // Down from 01 crosses the bottom wrap, up crosses it back
      test_name = "edit";
      for (int f = 0; f < NUM_FIELDS; f++)
      begin
         hold_buttons(4'b0011, 1);
         hold_buttons(4'b0001, f);
         hold_buttons(4'b0100, 3);
         hold_buttons(4'b1000, 4);
         for (int n = 0; n < 12; n++)
            hold_buttons(4'(random_bits(2) << 2), 1);
         sweep_sequencer();
      end

      test_name = "load";
      for (int f = 0; f < NUM_FIELDS; f++)
         for (int n = 0; n < 4; n++)
         begin
            set_random_inputs();
            load_sel = 4'(f);
            read = 1'b1;
            @(negedge reloj);
            read = 1'b0;
            sweep_sequencer();
         end
      // Select codes above 2 load nothing
      set_random_inputs();
      load_sel = 4'(3 + random_bits(4) % 13);
      read = 1'b1;
      @(negedge reloj);
      read = 1'b0;
      sweep_sequencer();

      // Strobe lands on the tick edge that edits the same field
      test_name = "load with edit";
      for (int f = 0; f < NUM_FIELDS; f++)
      begin
         hold_buttons(4'b0011, 1);
         hold_buttons(4'b0001, f);
         wait_for_count(TICK_DIV - 2, 2 * TICK_DIV);
         set_random_inputs();
         load_sel = 4'(f);
         read = 1'b1;
         buttons = 4'b1000;
         @(negedge reloj);
         read = 1'b0;
         @(negedge reloj);
         buttons = 4'b0000;
         sweep_sequencer();
      end

      test_name = "sequencer";
      for (int n = 0; n < 80; n++)
      begin
         enable_cont_16 = 1'(random_bits(1));
         enable_cont_fecha = 1'(random_bits(1));
         @(negedge reloj);
      end
      sweep_sequencer();
      repeat (2) @(negedge reloj);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+verif
hdl/fecha_pkg.sv
hdl/fecha_control.sv
hdl/fecha_field_editor.sv
hdl/fecha_bus_sequencer.sv
hdl/bloque_fecha.sv
verif/tb_bloque_fecha.sv
